/* tb.f */
+incdir+common
common/bpredPkg.sv
common/tableWriteIf.sv
hw/dirPredictor/ram2p1r1wb.sv
hw/dirPredictor/predIndexHash.sv
hw/dirPredictor/counterUpdate.sv
hw/dirPredictor/predResult.sv
hw/dirPredictor/dirPredictor.sv
verif/dirPredictorTb.sv

/* run.sh */
#!/bin/sh
# build the gshare predictor testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -f tb.f --top-module dirPredictorTb -o simv \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* verif/dirPredictorTb.sv */
// gshare direction predictor testbench
// reference table and history model with concurrent assertions on the outputs

`timescale 1ns/1ps
`include "bpred_config.svh"

module dirPredictorTb import bpredPkg::*; ();

  logic  clk = 1'b0;
  logic  reset;
  logic  lookupValid;
  pcT    lookupPc;
  logic  updateValid;
  indexT updateIndex;
  ctrT   updateCounter;
  logic  updateTaken;
  logic  ready;
  logic  predValid;
  logic  predTaken;
  ctrT   predCounter;
  indexT predIndex;

  // reference model
  ctrT   modelTable [0:2**`BPRED_INDEX_BITS-1];
  histT  modelHist;
  logic  modelReady;
  indexT walkCount;
  // expected prediction registered like the DUT result stage
  logic  expValid;
  indexT expIndex;
  ctrT   expCounter;

  // failures per checker
  int validFails;
  int indexFails;
  int counterFails;
  int readyFails;
  int checkFails;
  int testCount;

  dirPredictor dut_i (
    .clk           (clk),
    .reset         (reset),
    .lookupValid   (lookupValid),
    .lookupPc      (lookupPc),
    .updateValid   (updateValid),
    .updateIndex   (updateIndex),
    .updateCounter (updateCounter),
    .updateTaken   (updateTaken),
    .ready         (ready),
    .predValid     (predValid),
    .predTaken     (predTaken),
    .predCounter   (predCounter),
    .predIndex     (predIndex)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // saturating step up on taken and down on not-taken
  function automatic ctrT satStep(input ctrT c, input logic taken);
    if (taken) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  function automatic int totalErrors();
    return validFails + indexFails + counterFails + readyFails + checkFails;
  endfunction

  // random pc that hashes to idx under the current history
  function automatic pcT pcFor(input indexT idx);
    pcT pc;
    pc = $urandom();
    pc[`BPRED_INDEX_BITS+1:2] = idx ^ indexT'(modelHist);
    return pc;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    indexT lkIdx;
    ctrT   nxt;
    ctrT   upd;
    if (reset) begin
      modelHist  <= '0;
      modelReady <= 1'b0;
      walkCount  <= '0;
      expValid   <= 1'b0;
    end else begin
      // lookup sees history and table as they stand before this edge
      lkIdx = lookupPc[`BPRED_INDEX_BITS+1:2] ^ indexT'(modelHist);
      expValid <= lookupValid & modelReady;
      if (lookupValid && modelReady) begin
        expIndex   <= lkIdx;
        expCounter <= modelTable[lkIdx];
      end
      if (!modelReady) begin
        // walk fills weakly not-taken while updates are dropped
        modelTable[walkCount] <= ctrT'(1);
        walkCount <= walkCount + indexT'(1);
        if (walkCount == '1) begin
          modelReady <= 1'b1;
        end
      end else if (updateValid) begin
        // bits that flip in the step overwrite the stored entry
        nxt = satStep(updateCounter, updateTaken);
        upd = modelTable[updateIndex];
        for (int b = 0; b < `BPRED_CTR_BITS; b++) begin
          if (nxt[b] != updateCounter[b]) begin
            upd[b] = nxt[b];
          end
        end
        modelTable[updateIndex] <= upd;
        modelHist <= {modelHist[`BPRED_HIST_BITS-2:0], updateTaken};
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // predValid exactly one cycle after each gated lookup
  predValidCheck: assert property (@(posedge clk) disable iff (reset) predValid == expValid)
    else begin
      validFails++;
      $display("FAILED %0t: predValid %0b, expected %0b", $time,
               $sampled(predValid), $sampled(expValid));
    end

  predIndexCheck: assert property (@(posedge clk) disable iff (reset)
                                   predValid |-> predIndex == expIndex)
    else begin
      indexFails++;
      $display("FAILED %0t: predIndex %0d, expected %0d", $time,
               $sampled(predIndex), $sampled(expIndex));
    end

  // counter and its upper bit as the direction
  predCounterCheck: assert property (@(posedge clk) disable iff (reset)
    predValid |-> (predCounter == expCounter && predTaken == expCounter[`BPRED_CTR_BITS-1]))
    else begin
      counterFails++;
      $display("FAILED %0t: predCounter %0d taken %0b, expected counter %0d", $time,
               $sampled(predCounter), $sampled(predTaken), $sampled(expCounter));
    end

  // ready stays low for the whole walk
  readyCheck: assert property (@(posedge clk) disable iff (reset) ready == modelReady)
    else begin
      readyFails++;
      $display("FAILED %0t: ready %0b, expected %0b", $time,
               $sampled(ready), $sampled(modelReady));
    end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic clearInputs();
    lookupValid   = 1'b0;
    lookupPc      = '0;
    updateValid   = 1'b0;
    updateIndex   = '0;
    updateCounter = '0;
    updateTaken   = 1'b0;
  endtask

  // single lookup with the result sampled at the next falling edge
  task automatic lookupIndex(input indexT idx, output ctrT ctr);
    lookupValid = 1'b1;
    lookupPc    = pcFor(idx);
    @(negedge clk);
    lookupValid = 1'b0;
    ctr = predCounter;
    assert (predValid && predIndex == idx)
      else begin
        checkFails++;
        $display("FAILED %0t: no prediction for index %0d", $time, idx);
      end
  endtask

  task automatic updateEntry(input indexT idx, input ctrT ctr, input logic taken);
    updateValid   = 1'b1;
    updateIndex   = idx;
    updateCounter = ctr;
    updateTaken   = taken;
    @(negedge clk);
    updateValid = 1'b0;
  endtask

  // predTaken is still the same prediction when this runs
  task automatic expectCounter(input ctrT got, input ctrT exp, input string what);
    assert (got == exp && predTaken == exp[`BPRED_CTR_BITS-1])
      else begin
        checkFails++;
        $display("FAILED %0t: %s, counter %0d taken %0b, expected %0d", $time,
                 what, got, predTaken, exp);
      end
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testCount++;
    $display("test %0d %s: %0d errors", testCount, name, totalErrors() - startErrors);
  endtask

  task automatic waitReady(output logic ok);
    int n;
    n = 0;
    while (!ready && n < 1100) begin
      @(negedge clk);
      n++;
    end
    ok = ready;
  endtask

  //////////////////////////////////////////////////
  // tests after the walk
  //////////////////////////////////////////////////

  task automatic runTests(input int startErrors);
    indexT idx;
    ctrT   c;
    ctrT   oldCtr;
    logic  taken;
    pcT    pc;
    histT  pattern;
    int    errs;
    indexT qIdx[$];
    ctrT   qCtr[$];
    for (int k = 0; k < 64; k++) begin
      // entry 0 first since an update hit it during the walk
      idx = (k == 0) ? '0 : indexT'($urandom());
      lookupIndex(idx, c);
      expectCounter(c, ctrT'(1), "initialized entry");
    end
    reportTest("init walk", startErrors);

    // taken steps 1 -> 2 -> 3 -> 3
    errs = totalErrors();
    idx = indexT'($urandom());
    lookupIndex(idx, c);
    for (int k = 0; k < 3; k++) begin
      taken = 1'b1;
      updateEntry(idx, c, taken);
      lookupIndex(idx, c);
      expectCounter(c, ctrT'(k < 1 ? 2 : 3), "taken step");
    end
    reportTest("saturate taken", errs);

    // not-taken steps 3 -> 2 -> 1 -> 0 -> 0
    errs = totalErrors();
    for (int k = 0; k < 4; k++) begin
      updateEntry(idx, c, 1'b0);
      lookupIndex(idx, c);
      expectCounter(c, ctrT'(k < 3 ? 2 - k : 0), "not-taken step");
    end
    reportTest("saturate not-taken", errs);

    // after ten known outcomes the history equals the pattern
    errs = totalErrors();
    pattern = histT'(10'b1011001110);
    for (int k = `BPRED_HIST_BITS-1; k >= 0; k--) begin
      idx = indexT'($urandom());
      updateEntry(idx, modelTable[idx], pattern[k]);
    end
    for (int k = 0; k < 32; k++) begin
      pc = $urandom();
      lookupValid = 1'b1;
      lookupPc    = pc;
      @(negedge clk);
      lookupValid = 1'b0;
      assert (predValid && predIndex == (pc[`BPRED_INDEX_BITS+1:2] ^ indexT'(pattern)))
        else begin
          checkFails++;
          $display("FAILED %0t: hash of pc %h gave index %0d", $time, pc, predIndex);
        end
    end
    reportTest("history hash", errs);

    // same-cycle lookup and update return the old counter
    errs = totalErrors();
    idx = indexT'($urandom());
    lookupIndex(idx, c);
    // model entry before the write
    oldCtr = modelTable[idx];
    taken = (oldCtr != 2'd3);
    lookupValid   = 1'b1;
    lookupPc      = pcFor(idx);
    updateValid   = 1'b1;
    updateIndex   = idx;
    updateCounter = c;
    updateTaken   = taken;
    @(negedge clk);
    updateValid = 1'b0;
    expectCounter(predCounter, oldCtr, "lookup beside update");
    lookupPc = pcFor(idx);
    @(negedge clk);
    lookupValid = 1'b0;
    expectCounter(predCounter, satStep(oldCtr, taken), "lookup after update");
    reportTest("write then read", errs);

    // random traffic where updates return earlier predictions
    errs = totalErrors();
    for (int k = 0; k < 400; k++) begin
      if (predValid) begin
        qIdx.push_back(predIndex);
        qCtr.push_back(predCounter);
      end
      lookupValid = 1'($urandom_range(0, 1));
      lookupPc    = $urandom();
      updateValid = 1'b0;
      if (qIdx.size() > 0 && $urandom_range(0, 2) != 0) begin
        updateValid   = 1'b1;
        updateIndex   = qIdx.pop_front();
        updateCounter = qCtr.pop_front();
        updateTaken   = 1'($urandom_range(0, 1));
      end
      @(negedge clk);
    end
    clearInputs();
    // let the last results pass the assertions
    repeat (2) @(negedge clk);
    reportTest("random mix", errs);

    errs = totalErrors();
    $display("tests %0d, errors %0d", testCount, errs);
    if (errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    logic readyOk;
    int   startErrors;
    void'($urandom(32'h442f1e02));
    validFails   = 0;
    indexFails   = 0;
    counterFails = 0;
    readyFails   = 0;
    checkFails   = 0;
    testCount    = 0;
    reset = 1'b1;
    clearInputs();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    startErrors = totalErrors();
    // lookups and one update while the walker runs are all dropped
    // the update aims at entry 0 which the walker has already filled
    for (int k = 0; k < 20; k++) begin
      lookupValid   = 1'b1;
      lookupPc      = $urandom();
      updateValid   = (k == 5);
      updateIndex   = '0;
      updateCounter = ctrT'(1);
      updateTaken   = 1'b1;
      @(negedge clk);
    end
    clearInputs();
    waitReady(readyOk);
    if (!readyOk) begin
      $display("ready did not rise within 1100 cycles after reset");
      $display("Regression failed");
      $finish;
    end else begin
      runTests(startErrors);
    end
  end

endmodule

/* hw/dirPredictor/dirPredictor.sv */
// gshare branch direction predictor top
// decode hash, counter table, execute update and result stage

`timescale 1ns/1ps

module dirPredictor import bpredPkg::*; (
  input  logic  clk,
  input  logic  reset,

  // lookup request
  input  logic  lookupValid,
  input  pcT    lookupPc,

  // resolved branch
  input  logic  updateValid,
  input  indexT updateIndex,
  input  ctrT   updateCounter,
  input  logic  updateTaken,

  // table initialized
  output logic  ready,

  // prediction, one cycle after the lookup
  output logic  predValid,
  output logic  predTaken,
  output ctrT   predCounter,
  output indexT predIndex
);

  // hashed lookup index
  indexT index;

  // lookup and update strobes, dropped while the walker runs
  logic  lookupGo;
  logic  historyShift;

  // counter from the table read port
  ctrT   readCounter;

  // masked table write
  tableWriteIf tableWr ();

  assign lookupGo     = lookupValid & ready;
  // ignored updates leave the history alone too
  assign historyShift = updateValid & ready;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  predIndexHash decode_i (
    .clk         (clk),
    .reset       (reset),
    .lookupPc    (lookupPc),
    .updateValid (historyShift),
    .updateTaken (updateTaken),
    .index       (index)
  );

  //////////////////////////////////////////////////
  // counter table
  //////////////////////////////////////////////////

  ram2p1r1wb table_i (
    .clk   (clk),
    .reset (reset),
    .ra1   (index),
    .ren1  (lookupGo),
    .rd1   (readCounter),
    .wr    (tableWr.memory)
  );

  //////////////////////////////////////////////////
  // execute and result
  //////////////////////////////////////////////////

  counterUpdate execute_i (
    .clk           (clk),
    .reset         (reset),
    .updateValid   (updateValid),
    .updateIndex   (updateIndex),
    .updateCounter (updateCounter),
    .updateTaken   (updateTaken),
    .ready         (ready),
    .wr            (tableWr.writer)
  );

  predResult result_i (
    .clk         (clk),
    .reset       (reset),
    .lookupValid (lookupGo),
    .index       (index),
    .readCounter (readCounter),
    .predValid   (predValid),
    .predTaken   (predTaken),
    .predCounter (predCounter),
    .predIndex   (predIndex)
  );

endmodule

/* hw/dirPredictor/predResult.sv */
// gshare result stage
// lines up the lookup strobe and index with the registered SRAM read
// and forms the taken prediction

`timescale 1ns/1ps
`include "bpred_config.svh"

module predResult import bpredPkg::*; (
  input  logic  clk,
  input  logic  reset,

  // gated lookup strobe and its table index
  input  logic  lookupValid,
  input  indexT index,

  // counter from the SRAM read register
  input  ctrT   readCounter,

  // prediction, valid the cycle after the lookup
  output logic  predValid,
  output logic  predTaken,
  output ctrT   predCounter,
  output indexT predIndex
);

  //////////////////////////////////////////////////
  // strobe and index registers
  //////////////////////////////////////////////////

  // valid follows the lookup by one cycle, same as the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      predValid <= 1'b0;
    end else begin
      predValid <= lookupValid;
    end
  end

  // index is handed back to the caller for the later update
  // held between lookups like the read register
  always_ff @(posedge clk) begin
    if (lookupValid) begin
      predIndex <= index;
    end
  end

  //////////////////////////////////////////////////
  // prediction
  //////////////////////////////////////////////////

  // counter goes straight out so the caller can return it
  assign predCounter = readCounter;

  // upper bit set means weakly or strongly taken
  assign predTaken = readCounter[`BPRED_CTR_BITS-1];

endmodule

/* hw/dirPredictor/counterUpdate.sv */
// gshare execute stage
// fills the table with weakly not-taken after reset, then turns each
// resolved branch into a saturating counter step and a masked table write

`timescale 1ns/1ps
`include "bpred_config.svh"

module counterUpdate import bpredPkg::*; (
  input  logic  clk,
  input  logic  reset,

  // resolved branch, with the index and counter returned by its lookup
  input  logic  updateValid,
  input  indexT updateIndex,
  input  ctrT   updateCounter,
  input  logic  updateTaken,

  // high once the whole table is initialized
  output logic  ready,

  // table write port
  tableWriteIf.writer wr
);

  // walker state and current entry
  initStateT state;
  indexT     walkIdx;

  // saturating step result and its changed bits
  ctrT       nextCounter;
  ctrT       changedBits;

  // update accepted this cycle
  logic      updateGo;

  //////////////////////////////////////////////////
  // table walker
  //////////////////////////////////////////////////

  // one entry per cycle, 1024 cycles for the full table
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= Walk;
      walkIdx <= '0;
    end else begin
      case (state)
        Walk: begin
          walkIdx <= walkIdx + indexT'(1);
          // last entry written at this edge
          if (walkIdx == '1) begin
            state <= Ready;
          end
        end
        default: begin
          state <= Ready;
        end
      endcase
    end
  end

  assign ready = (state == Ready);

  //////////////////////////////////////////////////
  // saturating counter step
  //////////////////////////////////////////////////

  always_comb begin
    nextCounter = updateCounter;
    if (updateTaken) begin
      // count up, stop at strongly taken
      if (updateCounter != '1) begin
        nextCounter = updateCounter + ctrT'(1);
      end
    end else begin
      // count down, stop at strongly not-taken
      if (updateCounter != '0) begin
        nextCounter = updateCounter - ctrT'(1);
      end
    end
  end

  // only the bits that flip get written
  assign changedBits = nextCounter ^ updateCounter;

  // updates are ignored while the walk runs,
  // and a saturated counter needs no write
  assign updateGo = ready & updateValid & (changedBits != '0);

  //////////////////////////////////////////////////
  // write port mux
  //////////////////////////////////////////////////

  // walker owns the port until ready
  always_comb begin
    if (state == Walk) begin
      wr.wen  = 1'b1;
      wr.addr = walkIdx;
      // weakly not-taken with a full mask
      wr.data = ctrT'(1);
      wr.mask = '1;
    end else begin
      wr.wen  = updateGo;
      wr.addr = updateIndex;
      wr.data = nextCounter;
      wr.mask = changedBits;
    end
  end

endmodule

/* hw/dirPredictor/predIndexHash.sv */
// gshare decode stage
// keeps the global branch history and hashes it with the fetch PC
// into a counter table index

`timescale 1ns/1ps
`include "bpred_config.svh"

module predIndexHash import bpredPkg::*; (
  input  logic  clk,
  input  logic  reset,

  // lookup address
  input  pcT    lookupPc,

  // resolved branch outcome
  input  logic  updateValid,
  input  logic  updateTaken,

  // table index for this lookup
  output indexT index
);

  // global history register, newest outcome in the low bit
  histT history;

  // PC bits used in the hash
  indexT pcBits;

  //////////////////////////////////////////////////
  // history register
  //////////////////////////////////////////////////

  // shift in each resolved outcome at its update edge
  // history is not speculative, no repair path
  always_ff @(posedge clk) begin
    if (reset) begin
      history <= '0;
    end else if (updateValid) begin
      history <= {history[`BPRED_HIST_BITS-2:0], updateTaken};
    end
  end

  //////////////////////////////////////////////////
  // index hash
  //////////////////////////////////////////////////

  // skip the two byte-offset bits of the pc
  assign pcBits = lookupPc[`BPRED_INDEX_BITS+1:2];

  // gshare hash
  // uses the history as it stands before the lookup edge,
  // so an update in the same cycle does not affect this index
  assign index = pcBits ^ indexT'(history);

endmodule

/* hw/dirPredictor/ram2p1r1wb.sv */
// two-port counter SRAM
// one registered read port and one bit-masked write port,
// flop based model with typical SRAM read timing

`timescale 1ns/1ps
`include "bpred_config.svh"

module ram2p1r1wb import bpredPkg::*; #(
  parameter int DEPTH = `BPRED_INDEX_BITS,
  parameter int WIDTH = `BPRED_CTR_BITS
) (
  input  logic  clk,
  input  logic  reset,

  // read port
  input  indexT ra1,
  input  logic  ren1,
  output ctrT   rd1,

  // write port
  tableWriteIf.memory wr
);

  // storage array, contents are left unknown until the walker fills them
  logic [WIDTH-1:0] mem [0:2**DEPTH-1];

  // write enables per bit
  logic [WIDTH-1:0] bitWen;

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // registered read, data shows up the cycle after the enable
  // holds the last value while no read is issued
  // a write to the same entry in the same cycle is not forwarded
  always_ff @(posedge clk) begin
    if (reset) begin
      rd1 <= '0;
    end else if (ren1) begin
      rd1 <= mem[ra1];
    end
  end

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  assign bitWen = {WIDTH{wr.wen}} & wr.mask;

  // merge the new bits into the stored word
  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.addr] <= (wr.data & bitWen) | (mem[wr.addr] & ~bitWen);
    end
  end

endmodule

/* common/tableWriteIf.sv */
// counter table write port
// carries the masked write from the counter updater to the SRAM

`timescale 1ns/1ps

interface tableWriteIf import bpredPkg::*; ();

  // write strobe, one entry per cycle
  logic wen;

  // entry being written
  indexT addr;

  // new counter value
  ctrT data;

  // bit mask, only set bits of data are written
  // bits left clear keep the stored value
  ctrT mask;

  // counter updater side, drives the whole port
  modport writer (
    output wen,
    output addr,
    output data,
    output mask
  );

  // SRAM side, samples the port at the rising edge
  modport memory (
    input wen,
    input addr,
    input data,
    input mask
  );

endinterface

/* common/bpredPkg.sv */
// gshare predictor types
// vector types for pc, table index, history and counters,
// plus the state type of the table init walker

`include "bpred_config.svh"

package bpredPkg;

  //////////////////////////////////////////////////
  // datapath vectors
  //////////////////////////////////////////////////

  // fetch address of the branch being looked up
  typedef logic [`BPRED_PC_BITS-1:0] pcT;

  // entry number in the counter table
  typedef logic [`BPRED_INDEX_BITS-1:0] indexT;

  // global history, newest outcome in bit 0
  typedef logic [`BPRED_HIST_BITS-1:0] histT;

  // 2-bit saturating counter
  // 0 strongly not-taken
  // 1 weakly not-taken
  // 2 weakly taken
  // 3 strongly taken
  // the upper bit is the taken prediction
  typedef logic [`BPRED_CTR_BITS-1:0] ctrT;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  // table walker after reset
  // Walk fills every entry, Ready serves lookups and updates
  typedef enum logic {
    Walk,
    Ready
  } initStateT;

endpackage

/* common/bpred_config.svh */
// gshare direction predictor configuration
// table geometry, history length and fetch address width

`ifndef BPRED_CONFIG_SVH
`define BPRED_CONFIG_SVH

//////////////////////////////////////////////////
// table geometry
//////////////////////////////////////////////////

// index width, so the table holds 2**10 = 1024 entries
`define BPRED_INDEX_BITS 10

// width of each saturating counter
`define BPRED_CTR_BITS 2

//////////////////////////////////////////////////
// history and fetch address
//////////////////////////////////////////////////

// global history length, kept equal to the index width for gshare
`define BPRED_HIST_BITS 10

// fetch PC width
`define BPRED_PC_BITS 32

`endif
